/* filelist.f */
+incdir+verilog
verilog/qtable_pkg.sv
verilog/mem_req_if.sv
verilog/table_mem_port.sv
verilog/entry_sequencer.sv
verilog/qtable_update.sv
bench/qtable_checker.sv
bench/tb_qtable_update.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timing -f filelist.f \
		--top-module tb_qtable_update -Mdir obj_dir
	./obj_dir/Vtb_qtable_update | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_qtable_update.sv */
`include "qtable_macros.svh"

module tb_qtable_update;

        localparam int          MEM_WORDS  = 1024;              // 2 KiB table space
        localparam int          OP_TIMEOUT = 2000;              // cycles per operation
        localparam logic [31:0] SEED       = 32'h944d_e0d2;

        logic                   clock = 1'b0;
        logic                   nrst = 1'b0;
        logic                   start = 1'b0;
        qtable_pkg::word_t      source_id = '0;
        qtable_pkg::word_t      energy = '0;
        qtable_pkg::word_t      q_value = '0;
        qtable_pkg::word_t      cluster_id = '0;
        qtable_pkg::word_t      data_in = '0;
        qtable_pkg::addr_t      address;
        qtable_pkg::word_t      data_out;
        logic                   wr_en;
        logic                   done;
        logic                   full;

        qtable_pkg::word_t      mem [MEM_WORDS];        // external memory model
        qtable_pkg::word_t      img [MEM_WORDS];        // staged image, then expected one
        logic                   load = 1'b0;            // copy img into mem on next edge
        logic                   expect_full = 1'b0;
        string                  test_name = "";
        int                     ops = 0;                // operations started
        int                     checked = 0;            // operations compared

        always #5 clock = ~clock;

        qtable_update uut (
                .clock          (clock),
                .nrst           (nrst),
                .start          (start),
                .source_id      (source_id),
                .energy         (energy),
                .q_value        (q_value),
                .cluster_id     (cluster_id),
                .data_in        (data_in),
                .address        (address),
                .data_out       (data_out),
                .wr_en          (wr_en),
                .done           (done),
                .full           (full)
        );

        // writes land on the edge, read word follows the address by a cycle
        always @(posedge clock) begin
                int w;
                if (load) begin
                        for (w = 0; w < MEM_WORDS; w++)
                                mem[w] <= img[w];
                end else if (wr_en) begin
                        mem[address[`ADDR_W-1:1]] <= data_out;
                end
                data_in <= mem[address[`ADDR_W-1:1]];
        end

        task automatic fail_run();
                $display("*** FAILED ***");
                $fatal(1, "stopping at the first error");
        endtask

        function automatic int word_index(input int byte_addr);
                return byte_addr >> 1;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // reference model, returns the expected full flag
        ////////////////////////////////////////////////////////////////////////////

        function automatic logic expect_image(input qtable_pkg::word_t sid,
                                              input qtable_pkg::word_t en,
                                              input qtable_pkg::word_t q,
                                              input qtable_pkg::word_t cid);
                int ncnt;
                int kcnt;
                int slot;
                int i;
                ncnt = int'(img[word_index(`NEIGHBOR_COUNT_ADDR)]);
                kcnt = int'(img[word_index(`KNOWN_CH_COUNT_ADDR)]);
                if (kcnt > `MAX_KNOWN_CH)
                        kcnt = `MAX_KNOWN_CH;
                slot = ncnt;
                for (i = ncnt - 1; i >= 0; i--)         // lowest matching index wins
                        if (img[word_index(`NEIGHBOR_ID_BASE + 2 * i)] == sid)
                                slot = i;
                if (slot == ncnt && ncnt >= `MAX_NEIGHBORS)
                        return 1'b1;                    // table full, image untouched
                if (slot == ncnt) begin                 // new neighbor at index count
                        img[word_index(`NEIGHBOR_ID_BASE + 2 * slot)] = sid;
                        img[word_index(`NEIGHBOR_Q_BASE + 2 * slot)]  = q;
                        img[word_index(`CLUSTER_ID_BASE + 2 * slot)]  = cid;
                        img[word_index(`NEIGHBOR_COUNT_ADDR)] = qtable_pkg::word_t'(ncnt + 1);
                end
                img[word_index(`ENERGY_BASE + 2 * slot)] = en;
                for (i = 0; i < kcnt; i++)
                        img[word_index(`CH_ID_BASE + 16 * slot + 2 * i)] =
                                img[word_index(`KNOWN_CH_BASE + 2 * i)];
                img[word_index(`CH_ID_COUNT_BASE + 2 * slot)] = qtable_pkg::word_t'(kcnt);
                return 1'b0;
        endfunction

        // compare after each done, whole memory against img
        always @(negedge clock) begin
                int w;
                if (nrst && done) begin
                        assert (full === expect_full) else begin
                                $display("Mismatch %s full expected %0b actual %0b",
                                         test_name, expect_full, full);
                                fail_run();
                        end
                        @(negedge clock);               // last write lands after done
                        for (w = 0; w < MEM_WORDS; w++) begin
                                assert (mem[w] === img[w]) else begin
                                        $display("Mismatch %s addr 0x%03h %s 0x%04h %s 0x%04h",
                                                 test_name, w * 2, "expected", img[w],
                                                 "actual", mem[w]);
                                        fail_run();
                                end
                        end
                        checked++;
                end
        end

        task automatic load_image();
                @(posedge clock);
                load <= 1'b1;
                @(posedge clock);                       // model copies img here
                load <= 1'b0;
                @(posedge clock);
        endtask

        // fill pattern, ids 0x0a00+i, given counts
        task automatic build_table(input int ncnt, input int kcnt);
                int w;
                for (w = 0; w < MEM_WORDS; w++)
                        img[w] = qtable_pkg::word_t'((w << 6) ^ w ^ 'h3c00);
                for (w = 0; w < `MAX_NEIGHBORS; w++)
                        img[word_index(`NEIGHBOR_ID_BASE + 2 * w)] = qtable_pkg::word_t'('h0a00 + w);
                img[word_index(`NEIGHBOR_COUNT_ADDR)] = qtable_pkg::word_t'(ncnt);
                img[word_index(`KNOWN_CH_COUNT_ADDR)] = qtable_pkg::word_t'(kcnt);
                load_image();
        endtask

        task automatic run_op(input string name, input qtable_pkg::word_t sid,
                              input qtable_pkg::word_t en, input qtable_pkg::word_t q,
                              input qtable_pkg::word_t cid);
                int cyc;
                test_name   = name;
                expect_full = expect_image(sid, en, q, cid);
                ops++;
                source_id  <= sid;                      // held until done
                energy     <= en;
                q_value    <= q;
                cluster_id <= cid;
                start      <= 1'b1;
                @(posedge clock);
                start      <= 1'b0;
                cyc = 0;
                while (checked != ops) begin
                        if (cyc == OP_TIMEOUT) begin
                                $display("%s: done never came within %0d cycles", name, cyc);
                                fail_run();
                        end
                        @(posedge clock);
                        cyc++;
                end
        endtask

        initial begin
                int op;
                int ncnt;
                qtable_pkg::word_t sid;
                void'($urandom(SEED));
                repeat (16) @(posedge clock);
                nrst <= 1'b1;
                @(negedge clock);
                assert (!done && !full && !wr_en) else begin
                        $display("done, full or wr_en high after reset");
                        fail_run();
                end

                build_table(7, 5);                      // hit at a middle index
                run_op("update", 16'h0a03, 16'h1234, 16'h0055, 16'h00c1);
                build_table(5, 4);
                run_op("append", 16'h0bad, 16'h2222, 16'h0077, 16'h00c2);
                build_table(12, 6);
                run_op("full", 16'h0bad, 16'h3333, 16'h0011, 16'h00c3);
                build_table(4, 11);                     // known ch count above eight
                run_op("clamp", 16'h0a02, 16'h4444, 16'h0099, 16'h00c4);

                // random mix, image carries over between operations
                for (op = 0; op < 40; op++) begin
                        ncnt = $urandom_range(`MAX_NEIGHBORS, 0);
                        img[word_index(`NEIGHBOR_COUNT_ADDR)] = qtable_pkg::word_t'(ncnt);
                        img[word_index(`KNOWN_CH_COUNT_ADDR)] =
                                qtable_pkg::word_t'($urandom_range(12, 0));
                        img[word_index(`KNOWN_CH_BASE + 2 * $urandom_range(7, 0))] =
                                qtable_pkg::word_t'($urandom);
                        if (ncnt > 0 && $urandom_range(1, 0) == 1)
                                sid = img[word_index(`NEIGHBOR_ID_BASE +
                                                     2 * $urandom_range(ncnt - 1, 0))];
                        else
                                sid = qtable_pkg::word_t'($urandom);
                        load_image();
                        run_op($sformatf("random %0d", op), sid, qtable_pkg::word_t'($urandom),
                               qtable_pkg::word_t'($urandom), qtable_pkg::word_t'($urandom));
                end
                $display("*** PASSED ***");
                $finish;
        end

endmodule

/* bench/qtable_checker.sv */
// protocol checks on the engine's outer ports
module qtable_checker (
        input  logic                    clock,
        input  logic                    nrst,
        input  logic                    start,
        input  qtable_pkg::addr_t       address,
        input  logic                    wr_en,
        input  logic                    done,
        input  logic                    full
);

        logic idle;     // between done and the next accepted start

        always_ff @(posedge clock) begin
                if (!nrst)
                        idle <= 1'b1;
                else if (done)
                        idle <= 1'b1;
                else if (start && idle)
                        idle <= 1'b0;           // start only sampled while idle
        end

        ////////////////////////////////////////////////////////////////////////////
        // port properties
        ////////////////////////////////////////////////////////////////////////////

        // table words sit at even byte addresses
        a_even_write: assert property (@(posedge clock) disable iff (!nrst)
                wr_en |-> !address[0])
                else $error("write strobe with an odd address");

        a_done_pulse: assert property (@(posedge clock) disable iff (!nrst)
                done |=> !done)
                else $error("done held longer than one cycle");

        a_idle_quiet: assert property (@(posedge clock) disable iff (!nrst)
                idle |-> !wr_en)
                else $error("memory write while the engine is idle");

        // full is set only on the done cycle, then held
        a_full_done: assert property (@(posedge clock) disable iff (!nrst)
                $rose(full) |-> done)
                else $error("full raised without done");

endmodule

bind qtable_update qtable_checker u_checker (
        .clock          (clock),
        .nrst           (nrst),
        .start          (start),
        .address        (address),
        .wr_en          (wr_en),
        .done           (done),
        .full           (full)
);

/* verilog/qtable_update.sv */
// neighbor table update engine, top level
// start/done on the outside, valid/ready between sequencer and port
module qtable_update (
        input  logic                    clock,
        input  logic                    nrst,
        input  logic                    start,
        input  qtable_pkg::word_t       source_id,      // held from start to done
        input  qtable_pkg::word_t       energy,
        input  qtable_pkg::word_t       q_value,
        input  qtable_pkg::word_t       cluster_id,
        input  qtable_pkg::word_t       data_in,        // external table memory
        output qtable_pkg::addr_t       address,
        output qtable_pkg::word_t       data_out,
        output logic                    wr_en,
        output logic                    done,
        output logic                    full
);

        mem_req_if mem_if ();

        // control path
        entry_sequencer u_seq (
                .clock          (clock),
                .nrst           (nrst),
                .start          (start),
                .source_id      (source_id),
                .energy         (energy),
                .q_value        (q_value),
                .cluster_id     (cluster_id),
                .mem            (mem_if.seq),
                .done           (done),
                .full           (full)
        );

        // memory side
        table_mem_port u_port (
                .clock          (clock),
                .nrst           (nrst),
                .mem            (mem_if.port),
                .data_in        (data_in),
                .address        (address),
                .data_out       (data_out),
                .wr_en          (wr_en)
        );

endmodule

/* verilog/entry_sequencer.sv */
`include "qtable_macros.svh"

// neighbor table update FSM
// load counts, scan ids, then update or append, then copy cluster heads
module entry_sequencer (
        input  logic                    clock,
        input  logic                    nrst,
        input  logic                    start,
        input  qtable_pkg::word_t       source_id,
        input  qtable_pkg::word_t       energy,
        input  qtable_pkg::word_t       q_value,
        input  qtable_pkg::word_t       cluster_id,
        mem_req_if.seq                  mem,
        output logic                    done,
        output logic                    full
);

        typedef enum logic [3:0] {
                S_IDLE, S_LD_NCNT, S_LD_KCNT, S_SCAN, S_ENERGY,
                S_APP_ID, S_APP_Q, S_APP_CID,
                S_CH_RD, S_CH_WR, S_CH_CNT, S_NCNT_WR, S_DONE
        } state_e;

        state_e                 state;
        logic                   issued;         // read sent, waiting on rsp_valid
        logic                   append;         // new entry path
        logic                   xfer;
        logic                   scan_end;
        qtable_pkg::index_t     n;              // neighbor index
        qtable_pkg::index_t     k;              // cluster head index
        qtable_pkg::index_t     kcnt;           // clamped known ch count
        qtable_pkg::word_t      ncnt;           // neighbor count as read
        qtable_pkg::word_t      ch_word;        // cluster head being copied

        assign xfer     = mem.req_valid && mem.req_ready;
        assign scan_end = (qtable_pkg::word_t'(n) == ncnt);
        assign done     = (state == S_DONE);    // single cycle, then idle

        ////////////////////////////////////////////////////////////////////
        // request decode, held stable by the state until transfer
        ////////////////////////////////////////////////////////////////////

        always_comb begin
                mem.req_valid  = 1'b0;
                mem.req_write  = 1'b0;
                mem.req_region = qtable_pkg::REG_NEIGHBOR_ID;
                mem.req_n      = n;
                mem.req_k      = k;
                mem.req_wdata  = source_id;
                case (state)
                S_LD_NCNT: begin
                        mem.req_valid  = !issued;
                        mem.req_region = qtable_pkg::REG_NEIGHBOR_COUNT;
                end
                S_LD_KCNT: begin
                        mem.req_valid  = !issued;
                        mem.req_region = qtable_pkg::REG_KNOWN_CH_COUNT;
                end
                S_SCAN:    mem.req_valid = !issued && !scan_end;  // id at n
                S_APP_ID: begin
                        mem.req_valid  = 1'b1;
                        mem.req_write  = 1'b1;
                end
                S_ENERGY: begin
                        mem.req_valid  = 1'b1;
                        mem.req_write  = 1'b1;
                        mem.req_region = qtable_pkg::REG_ENERGY;
                        mem.req_wdata  = energy;
                end
                S_APP_Q: begin
                        mem.req_valid  = 1'b1;
                        mem.req_write  = 1'b1;
                        mem.req_region = qtable_pkg::REG_NEIGHBOR_Q;
                        mem.req_wdata  = q_value;
                end
                S_APP_CID: begin
                        mem.req_valid  = 1'b1;
                        mem.req_write  = 1'b1;
                        mem.req_region = qtable_pkg::REG_CLUSTER_ID;
                        mem.req_wdata  = cluster_id;
                end
                S_CH_RD: begin
                        mem.req_valid  = !issued && (k != kcnt);
                        mem.req_region = qtable_pkg::REG_KNOWN_CH;
                end
                S_CH_WR: begin
                        mem.req_valid  = 1'b1;
                        mem.req_write  = 1'b1;
                        mem.req_region = qtable_pkg::REG_CH_ID;
                        mem.req_wdata  = ch_word;
                end
                S_CH_CNT: begin
                        mem.req_valid  = 1'b1;
                        mem.req_write  = 1'b1;
                        mem.req_region = qtable_pkg::REG_CH_COUNT;
                        mem.req_wdata  = qtable_pkg::word_t'(kcnt);
                end
                S_NCNT_WR: begin
                        mem.req_valid  = 1'b1;
                        mem.req_write  = 1'b1;
                        mem.req_region = qtable_pkg::REG_NEIGHBOR_COUNT;
                        mem.req_wdata  = ncnt + 1'b1;
                end
                default: ;
                endcase
        end

        ////////////////////////////////////////////////////////////////////
        // state register
        ////////////////////////////////////////////////////////////////////

        always_ff @(posedge clock) begin
                if (!nrst) begin
                        state  <= S_IDLE;
                        issued <= 1'b0;
                        append <= 1'b0;
                        full   <= 1'b0;
                        n      <= '0;
                        k      <= '0;
                end else begin
                        if (xfer && !mem.req_write)
                                issued <= 1'b1;
                        if (mem.rsp_valid)
                                issued <= 1'b0;
                        case (state)
                        S_IDLE: if (start) begin
                                n      <= '0;
                                k      <= '0;
                                append <= 1'b0;
                                full   <= 1'b0;        // held from last done until here
                                state  <= S_LD_NCNT;
                        end
                        S_LD_NCNT: if (mem.rsp_valid) begin
                                ncnt  <= mem.rsp_rdata;
                                state <= S_LD_KCNT;
                        end
                        S_LD_KCNT: if (mem.rsp_valid) begin
                                kcnt  <= (mem.rsp_rdata > `MAX_KNOWN_CH) ?
                                         qtable_pkg::index_t'(`MAX_KNOWN_CH) :
                                         qtable_pkg::index_t'(mem.rsp_rdata);
                                state <= S_SCAN;
                        end
                        S_SCAN: if (scan_end) begin
                                if (ncnt < `MAX_NEIGHBORS) begin
                                        append <= 1'b1;  // n already equals count
                                        state  <= S_APP_ID;
                                end else begin
                                        full   <= 1'b1;  // no room, nothing written
                                        state  <= S_DONE;
                                end
                        end else if (mem.rsp_valid) begin
                                if (mem.rsp_rdata == source_id)
                                        state <= S_ENERGY;
                                else
                                        n <= n + 1'b1;
                        end
                        S_APP_ID:  if (xfer) state <= S_ENERGY;
                        S_ENERGY:  if (xfer) state <= append ? S_APP_Q : S_CH_RD;
                        S_APP_Q:   if (xfer) state <= S_APP_CID;
                        S_APP_CID: if (xfer) state <= S_CH_RD;
                        S_CH_RD: if (k == kcnt) begin
                                state <= S_CH_CNT;
                        end else if (mem.rsp_valid) begin
                                ch_word <= mem.rsp_rdata;
                                state   <= S_CH_WR;
                        end
                        S_CH_WR: if (xfer) begin
                                k     <= k + 1'b1;
                                state <= S_CH_RD;
                        end
                        S_CH_CNT:  if (xfer) state <= append ? S_NCNT_WR : S_DONE;
                        S_NCNT_WR: if (xfer) state <= S_DONE;
                        default:   state <= S_IDLE;    // S_DONE
                        endcase
                end
        end

endmodule

/* verilog/table_mem_port.sv */
`include "qtable_macros.svh"

// memory access unit
// maps region/index requests onto the byte-addressed table memory
module table_mem_port (
        input  logic                    clock,
        input  logic                    nrst,
        mem_req_if.port                 mem,
        input  qtable_pkg::word_t       data_in,        // word at last cycle's address
        output qtable_pkg::addr_t       address,
        output qtable_pkg::word_t       data_out,
        output logic                    wr_en
);

        qtable_pkg::addr_t      req_addr;       // decoded byte address
        qtable_pkg::addr_t      n_off;          // 2*n
        qtable_pkg::addr_t      k_off;          // 2*k
        qtable_pkg::addr_t      ch_row;         // 16*n, one ch list per neighbor
        logic                   xfer;
        logic                   rd_addr_cyc;    // read address on the bus
        logic                   rd_data_cyc;    // read word on data_in

        assign xfer   = mem.req_valid && mem.req_ready;
        assign n_off  = qtable_pkg::addr_t'(mem.req_n) << 1;
        assign k_off  = qtable_pkg::addr_t'(mem.req_k) << 1;
        assign ch_row = qtable_pkg::addr_t'(mem.req_n) << 4;

        ////////////////////////////////////////////////////////////////////
        // address decode
        ////////////////////////////////////////////////////////////////////

        always_comb begin
                case (mem.req_region)
                qtable_pkg::REG_KNOWN_CH:       req_addr = `KNOWN_CH_BASE + k_off;
                qtable_pkg::REG_NEIGHBOR_ID:    req_addr = `NEIGHBOR_ID_BASE + n_off;
                qtable_pkg::REG_CLUSTER_ID:     req_addr = `CLUSTER_ID_BASE + n_off;
                qtable_pkg::REG_ENERGY:         req_addr = `ENERGY_BASE + n_off;
                qtable_pkg::REG_NEIGHBOR_Q:     req_addr = `NEIGHBOR_Q_BASE + n_off;
                qtable_pkg::REG_CH_ID:          req_addr = `CH_ID_BASE + ch_row + k_off;
                qtable_pkg::REG_CH_COUNT:       req_addr = `CH_ID_COUNT_BASE + n_off;
                qtable_pkg::REG_KNOWN_CH_COUNT: req_addr = `KNOWN_CH_COUNT_ADDR;
                default:                        req_addr = `NEIGHBOR_COUNT_ADDR;
                endcase
        end

        ////////////////////////////////////////////////////////////////////
        // bus registers
        ////////////////////////////////////////////////////////////////////

        // control, one-cycle write strobe and read pipeline
        always_ff @(posedge clock) begin
                if (!nrst) begin
                        wr_en       <= 1'b0;
                        rd_addr_cyc <= 1'b0;
                        rd_data_cyc <= 1'b0;
                end else begin
                        wr_en       <= xfer && mem.req_write;
                        rd_addr_cyc <= xfer && !mem.req_write;
                        rd_data_cyc <= rd_addr_cyc;   // memory answers a cycle later
                end
        end

        // address and write data, loaded on every transfer
        always_ff @(posedge clock) begin
                if (xfer) begin
                        address  <= req_addr;
                        data_out <= mem.req_wdata;
                end
        end

        // stall new requests until the read word is handed back
        assign mem.req_ready = !(rd_addr_cyc || rd_data_cyc);
        assign mem.rsp_valid = rd_data_cyc;
        assign mem.rsp_rdata = data_in;         // sequencer latches it on rsp_valid

endmodule

/* verilog/mem_req_if.sv */
// table request channel, sequencer to memory port
// valid/ready on the request, fixed-latency read response
interface mem_req_if;

        // request side
        logic                   req_valid;
        logic                   req_ready;      // low while a read is in flight
        logic                   req_write;      // 1 write, 0 read
        qtable_pkg::region_e    req_region;
        qtable_pkg::index_t     req_n;          // neighbor index
        qtable_pkg::index_t     req_k;          // cluster head index
        qtable_pkg::word_t      req_wdata;

        // response side, two cycles after a read transfer
        logic                   rsp_valid;
        qtable_pkg::word_t      rsp_rdata;

        modport seq (
                output req_valid, req_write, req_region, req_n, req_k, req_wdata,
                input  req_ready, rsp_valid, rsp_rdata
        );

        modport port (
                input  req_valid, req_write, req_region, req_n, req_k, req_wdata,
                output req_ready, rsp_valid, rsp_rdata
        );

endinterface

/* verilog/qtable_pkg.sv */
`include "qtable_macros.svh"

package qtable_pkg;

        ////////////////////////////////////////////////////////////////////
        // basic table types
        ////////////////////////////////////////////////////////////////////

        typedef logic [`WORD_W-1:0]  word_t;    // one table word
        typedef logic [`ADDR_W-1:0]  addr_t;    // byte address
        typedef logic [`INDEX_W-1:0] index_t;   // neighbor or ch index

        // which table region a request points into
        // memory port turns region + index into a byte address
        typedef enum logic [3:0] {
                REG_KNOWN_CH,           // known ch list, indexed by k
                REG_NEIGHBOR_ID,        // indexed by n
                REG_CLUSTER_ID,
                REG_ENERGY,
                REG_NEIGHBOR_Q,
                REG_CH_ID,              // per neighbor ch list, n and k
                REG_CH_COUNT,           // per neighbor ch count
                REG_KNOWN_CH_COUNT,     // fixed word
                REG_NEIGHBOR_COUNT      // fixed word
        } region_e;

endpackage

/* verilog/qtable_macros.svh */
`ifndef QTABLE_MACROS_SVH
`define QTABLE_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////

`define WORD_W                  16              // table word
`define ADDR_W                  11              // byte address, 2 KiB space
`define INDEX_W                 4               // neighbor / cluster head index

// table limits
`define MAX_NEIGHBORS           12
`define MAX_KNOWN_CH            8               // copy clamp per neighbor

////////////////////////////////////////////////////////////////////////////
// memory map, byte addresses, words at even addresses
////////////////////////////////////////////////////////////////////////////

`define KNOWN_CH_BASE           11'h012         // node's own cluster head list
`define NEIGHBOR_ID_BASE        11'h072
`define CLUSTER_ID_BASE         11'h0B2
`define ENERGY_BASE             11'h0F2
`define NEIGHBOR_Q_BASE         11'h132
`define CH_ID_BASE              11'h1B2         // 16 bytes per neighbor
`define KNOWN_CH_COUNT_ADDR     11'h272
`define NEIGHBOR_COUNT_ADDR     11'h274
`define CH_ID_COUNT_BASE        11'h278         // one count word per neighbor

`endif
